/* dv/conv_assert.sv */
module conv_assert import conv_pkg::*; (
	input logic    clk,
	input logic    rst_n,
	input logic    image_valid,
	input logic    out_valid,
	input result_t out_data
);

	timeunit 1ns;
	timeprecision 1ps;

	// nothing comes out right after reset
	reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// results never overlap an image load
	no_load_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(out_valid && image_valid))
		else $error("out_valid and image_valid high together");

	data_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown(out_data))
		else $error("out_data unknown while out_valid is high");

endmodule

bind conv_top conv_assert conv_assert_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.image_valid (image_valid),
	.out_valid   (out_valid),
	.out_data    (out_data)
);

/* dv/conv_tb.sv */
module conv_tb import conv_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IMG_MAX     = 8;
	localparam int ALPHA       = 10;
	localparam int SEED        = 32;
	localparam int TIMEOUT_CYC = 200;
	localparam int QUIET_CYC   = 40;

	logic      clk;
	logic      rst_n;
	logic      filter_valid;
	logic      image_valid;
	img_size_t image_size;
	pad_mode_e pad_mode;
	act_mode_e act_mode;
	pixel_t    in_data;
	logic      out_valid;
	result_t   out_data;

	// copies of what was loaded, for the model
	pixel_t      filt [KER_TAPS];
	pixel_t      img [IMG_MAX*IMG_MAX];
	logic [31:0] lcg_state;
	result_t     got_q [$];
	int          err_cnt;
	int          test_cnt;

	conv_top #(.IMG_MAX(IMG_MAX), .ALPHA(ALPHA)) dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.filter_valid (filter_valid),
		.image_valid  (image_valid),
		.image_size   (image_size),
		.pad_mode     (pad_mode),
		.act_mode     (act_mode),
		.in_data      (in_data),
		.out_valid    (out_valid),
		.out_data     (out_data)
	);

	always #5 clk = ~clk;

	function automatic pixel_t rand_pixel();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return pixel_t'(lcg_state >> 24);
	endfunction

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------

	function automatic result_t model_pixel(int r, int c, int side, pad_mode_e pad,
			act_mode_e act);
		int acc;
		int sr;
		int sc;
		int pix;
		bit outside;
		acc = 0;
		for (int i = 0; i < KER; i++) begin
			for (int j = 0; j < KER; j++) begin
				sr = r + i - 1;
				sc = c + j - 1;
				outside = (sr < 0) || (sr >= side) || (sc < 0) || (sc >= side);
				sr = (sr < 0) ? 0 : ((sr >= side) ? side - 1 : sr);
				sc = (sc < 0) ? 0 : ((sc >= side) ? side - 1 : sc);
				pix = (outside && pad == PAD_ZERO) ? 0 : int'(img[sr * side + sc]);
				acc += int'(filt[i * KER + j]) * pix;
			end
		end
		if (acc < 0) begin
			acc = (act == ACT_LEAKY) ? acc / ALPHA : 0;
		end
		if (acc > 32767) begin
			acc = 32767;
		end else if (acc < -32768) begin
			acc = -32768;
		end
		return result_t'(acc);
	endfunction

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	task automatic check_result(result_t expected, result_t actual, string msg);
		if (actual !== expected) begin
			$display("MISMATCH at %0d ns: %s expected %0d got %0d", $time, msg, expected,
				actual);
			err_cnt++;
		end
	endtask

	task automatic check_count(img_size_t side, int actual);
		if (actual != int'(side) * int'(side)) begin
			$display("MISMATCH at %0d ns: result count expected %0d got %0d", $time,
				int'(side) * int'(side), actual);
			err_cnt++;
		end
	endtask

	task automatic report_test(string name, int errs_before);
		test_cnt++;
		$display("%s finished with %0d errors", name, err_cnt - errs_before);
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic load_filter();
		for (int k = 0; k < KER_TAPS; k++) begin
			@(posedge clk);
			#1;
			filter_valid = 1'b1;
			in_data      = filt[k];
		end
		@(posedge clk);
		#1;
		filter_valid = 1'b0;
		in_data      = '0;
	endtask

	task automatic load_image(int side, pad_mode_e pad, act_mode_e act);
		for (int k = 0; k < side * side; k++) begin
			@(posedge clk);
			#1;
			image_valid = 1'b1;
			image_size  = img_size_t'(side);
			pad_mode    = pad;
			act_mode    = act;
			in_data     = img[k];
		end
		@(posedge clk);
		#1;
		image_valid = 1'b0;
		in_data     = '0;
	endtask

	// top half positive so the upper rows tend to saturate
	task automatic fill_random(int side);
		for (int k = 0; k < side * side; k++) begin
			img[k] = rand_pixel();
			if (k / side < side / 2) begin
				img[k][7] = 1'b0;
			end
		end
	endtask

	// stray valids while the engine is busy
	task automatic pulse_valids();
		@(posedge clk);
		#1;
		filter_valid = 1'b1;
		image_valid  = 1'b1;
		in_data      = 8'sh55;
		@(posedge clk);
		#1;
		filter_valid = 1'b0;
		image_valid  = 1'b0;
		in_data      = '0;
	endtask

	task automatic wait_results(int n, bit poke);
		int idle;
		idle = 0;
		while (got_q.size() < n && idle < TIMEOUT_CYC) begin
			@(negedge clk);
			idle++;
			if (out_valid) begin
				got_q.push_back(out_data);
				idle = 0;
				if (poke && got_q.size() == 2) begin
					pulse_valids();
				end
			end
		end
		if (got_q.size() < n) begin
			$display("timeout: only %0d of %0d results arrived", got_q.size(), n);
			err_cnt++;
		end
	endtask

	task automatic count_late(output int late);
		late = 0;
		repeat (QUIET_CYC) begin
			@(negedge clk);
			if (out_valid) begin
				late++;
			end
		end
	endtask

	task automatic run_image(string name, int side, pad_mode_e pad, act_mode_e act, bit poke);
		int errs_before;
		int late;
		errs_before = err_cnt;
		got_q.delete();
		load_image(side, pad, act);
		wait_results(side * side, poke);
		count_late(late);
		check_count(img_size_t'(side), got_q.size() + late);
		for (int k = 0; k < got_q.size(); k++) begin
			check_result(model_pixel(k / side, k % side, side, pad, act), got_q[k],
				$sformatf("%s pixel (%0d,%0d)", name, k / side, k % side));
		end
		report_test(name, errs_before);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------

	task automatic test_small_relu();
		pixel_t hand [KER_TAPS];
		filt = '{1, 2, 1, 0, -1, 0, -2, 1, 3};
		hand = '{5, -3, 7, 2, 9, -6, 4, 1, -8};
		for (int k = 0; k < KER_TAPS; k++) begin
			img[k] = hand[k];
		end
		load_filter();
		run_image("small_relu", 3, PAD_ZERO, ACT_RELU, 1'b0);
	endtask

	task automatic test_leaky_replicate();
		filt = '{-3, -1, 2, -4, 1, -2, 0, -1, -5};
		for (int k = 0; k < 25; k++) begin
			img[k] = pixel_t'((k * 9) % 41 - 12);
		end
		load_filter();
		run_image("leaky_replicate", 5, PAD_REPLICATE, ACT_LEAKY, 1'b0);
	endtask

	task automatic test_random_8x8();
		for (int k = 0; k < KER_TAPS; k++) begin
			filt[k]    = rand_pixel();
			filt[k][7] = 1'b0;
		end
		load_filter();
		fill_random(8);
		run_image("random_zero", 8, PAD_ZERO, ACT_RELU, 1'b0);
		fill_random(8);
		run_image("random_replicate", 8, PAD_REPLICATE, ACT_LEAKY, 1'b0);
	endtask

	// filter from the previous test stays loaded
	task automatic test_filter_retained();
		fill_random(4);
		run_image("filter_retained", 4, PAD_ZERO, ACT_LEAKY, 1'b1);
	endtask

	task automatic test_reset_midway();
		int errs_before;
		int late;
		errs_before = err_cnt;
		got_q.delete();
		fill_random(6);
		load_image(6, PAD_REPLICATE, ACT_RELU);
		wait_results(3, 1'b0);
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		count_late(late);
		if (late != 0) begin
			$display("out_valid was high %0d times after the reset", late);
			err_cnt++;
		end
		report_test("reset_midway", errs_before);
		for (int k = 0; k < KER_TAPS; k++) begin
			filt[k] = rand_pixel();
		end
		load_filter();
		fill_random(3);
		run_image("after_reset", 3, PAD_REPLICATE, ACT_RELU, 1'b0);
	endtask

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		filter_valid = 1'b0;
		image_valid  = 1'b0;
		image_size   = 4'd3;
		pad_mode     = PAD_ZERO;
		act_mode     = ACT_RELU;
		in_data      = '0;
		lcg_state    = SEED;
		err_cnt      = 0;
		test_cnt     = 0;
		apply_reset();
		test_small_relu();
		test_leaky_replicate();
		test_random_8x8();
		test_filter_retained();
		test_reset_midway();
		$display("%0d tests run, %0d errors", test_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* flist.f */
hw/conv_pkg.sv
hw/filter_store.sv
hw/image_store.sv
hw/conv_sequencer.sv
hw/mac_act.sv
hw/conv_top.sv
dv/conv_assert.sv
dv/conv_tb.sv

/* hw/conv_pkg.sv */
package conv_pkg;

	// --------------------------------------------------
	// data widths
	// --------------------------------------------------

	// image pixel or filter weight
	typedef logic signed [7:0]  pixel_t;

	// one pixel times one weight
	typedef logic signed [15:0] prod_t;

	// nine products fit without overflow
	typedef logic signed [19:0] acc_t;

	// after activation and saturation
	typedef logic signed [15:0] result_t;

	localparam result_t RES_MAX = 16'sh7fff;
	localparam result_t RES_MIN = -16'sh8000;

	// --------------------------------------------------
	// geometry
	// --------------------------------------------------

	localparam int KER      = 3;
	localparam int KER_TAPS = KER * KER;

	typedef logic [3:0] coord_t;

	// legal sides are 3 to 8
	typedef logic [3:0] img_size_t;

	// --------------------------------------------------
	// modes
	// --------------------------------------------------

	typedef enum logic {PAD_ZERO = 1'b0, PAD_REPLICATE = 1'b1} pad_mode_e;

	typedef enum logic {ACT_RELU = 1'b0, ACT_LEAKY = 1'b1} act_mode_e;

endpackage

/* hw/conv_sequencer.sv */
module conv_sequencer import conv_pkg::*; #(
	parameter int IMG_MAX = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       load_done,
	input  img_size_t  size,
	input  pad_mode_e  pad_sel,
	input  act_mode_e  act_sel,
	output logic       busy,
	output coord_t     rd_row,
	output coord_t     rd_col,
	output logic       tap_valid,
	output logic [3:0] tap_index,
	output logic       tap_zero,
	output logic       first_tap,
	output logic       last_tap,
	output act_mode_e  act_out
);

	localparam logic [1:0] TAP_LAST  = 2'(KER - 1);
	// read plus MAC stages after the last tap
	localparam logic [1:0] DRAIN_CYC = 2'd2;

	logic       run;
	logic [1:0] drain;
	coord_t     out_r;
	coord_t     out_c;
	logic [1:0] tap_r;
	logic [1:0] tap_c;
	act_mode_e  act_q;
	img_size_t  sz;
	img_size_t  sz_last;
	logic [4:0] map_r;
	logic [4:0] map_c;
	logic       row_end;
	logic       img_end;

	// msb flags out of range, low bits hold the clamped index
	function automatic logic [4:0] map_coord(input coord_t base, input logic [1:0] tap,
			input img_size_t sz_in);
		logic [4:0] src;
		src = {1'b0, base} + {3'b000, tap} - 5'd1;
		if (src[4]) begin
			map_coord = {1'b1, 4'd0};
		end else if (src[3:0] >= sz_in) begin
			map_coord = {1'b1, sz_in - 4'd1};
		end else begin
			map_coord = {1'b0, src[3:0]};
		end
	endfunction

	assign sz      = (size > 4'(IMG_MAX)) ? 4'(IMG_MAX) : size;
	assign sz_last = sz - 4'd1;
	assign row_end = (out_c == sz_last);
	assign img_end = row_end && (out_r == sz_last);

	// --------------------------------------------------
	// tap address and flags
	// --------------------------------------------------

	assign map_r     = map_coord(out_r, tap_r, sz);
	assign map_c     = map_coord(out_c, tap_c, sz);
	assign rd_row    = map_r[3:0];
	assign rd_col    = map_c[3:0];
	assign tap_zero  = run && (pad_sel == PAD_ZERO) && (map_r[4] || map_c[4]);
	assign tap_valid = run;
	assign tap_index = {2'b00, tap_r} * 4'(KER) + {2'b00, tap_c};
	assign first_tap = run && (tap_r == 2'd0) && (tap_c == 2'd0);
	assign last_tap  = run && (tap_r == TAP_LAST) && (tap_c == TAP_LAST);
	assign act_out   = act_q;
	assign busy      = load_done || run || (drain != 2'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run   <= 1'b0;
			drain <= '0;
			out_r <= '0;
			out_c <= '0;
			tap_r <= '0;
			tap_c <= '0;
			act_q <= ACT_RELU;
		end else if (load_done) begin
			run   <= 1'b1;
			out_r <= '0;
			out_c <= '0;
			tap_r <= '0;
			tap_c <= '0;
			act_q <= act_sel;
		end else if (run) begin
			if (tap_c != TAP_LAST) begin
				tap_c <= tap_c + 2'd1;
			end else begin
				tap_c <= '0;
				if (tap_r != TAP_LAST) begin
					tap_r <= tap_r + 2'd1;
				end else begin
					tap_r <= '0;
					if (!row_end) begin
						out_c <= out_c + 4'd1;
					end else begin
						out_c <= '0;
						if (!img_end) begin
							out_r <= out_r + 4'd1;
						end else begin
							out_r <= '0;
							run   <= 1'b0;
							drain <= DRAIN_CYC;
						end
					end
				end
			end
		end else if (drain != 2'd0) begin
			drain <= drain - 2'd1;
		end
	end

endmodule

/* hw/conv_top.sv */
module conv_top import conv_pkg::*; #(
	parameter int IMG_MAX = 8,
	parameter int ALPHA   = 10
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      filter_valid,
	input  logic      image_valid,
	input  img_size_t image_size,
	input  pad_mode_e pad_mode,
	input  act_mode_e act_mode,
	input  pixel_t    in_data,
	output logic      out_valid,
	output result_t   out_data
);

	pixel_t     weights [KER_TAPS];
	logic       busy;
	logic       load_done;
	img_size_t  size;
	pad_mode_e  pad_sel;
	act_mode_e  act_sel;
	act_mode_e  act_run;
	coord_t     rd_row;
	coord_t     rd_col;
	pixel_t     rd_pixel;
	logic       tap_valid;
	logic [3:0] tap_index;
	logic       tap_zero;
	logic       first_tap;
	logic       last_tap;

	// --------------------------------------------------
	// load side
	// --------------------------------------------------

	filter_store filter_store_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.filter_valid (filter_valid),
		.busy         (busy),
		.in_data      (in_data),
		.weights      (weights)
	);

	image_store #(.IMG_MAX(IMG_MAX)) image_store_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.image_valid (image_valid),
		.busy        (busy),
		.in_data     (in_data),
		.image_size  (image_size),
		.pad_mode    (pad_mode),
		.act_mode    (act_mode),
		.size        (size),
		.pad_sel     (pad_sel),
		.act_sel     (act_sel),
		.load_done   (load_done),
		.rd_row      (rd_row),
		.rd_col      (rd_col),
		.rd_pixel    (rd_pixel)
	);

	// --------------------------------------------------
	// compute side
	// --------------------------------------------------

	conv_sequencer #(.IMG_MAX(IMG_MAX)) conv_sequencer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_done (load_done),
		.size      (size),
		.pad_sel   (pad_sel),
		.act_sel   (act_sel),
		.busy      (busy),
		.rd_row    (rd_row),
		.rd_col    (rd_col),
		.tap_valid (tap_valid),
		.tap_index (tap_index),
		.tap_zero  (tap_zero),
		.first_tap (first_tap),
		.last_tap  (last_tap),
		.act_out   (act_run)
	);

	mac_act #(.ALPHA(ALPHA)) mac_act_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.weights   (weights),
		.rd_pixel  (rd_pixel),
		.tap_valid (tap_valid),
		.tap_index (tap_index),
		.tap_zero  (tap_zero),
		.first_tap (first_tap),
		.last_tap  (last_tap),
		.act_out   (act_run),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

/* hw/filter_store.sv */
module filter_store import conv_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   filter_valid,
	input  logic   busy,
	input  pixel_t in_data,
	output pixel_t weights [KER_TAPS]
);

	logic [3:0] shift_cnt;
	logic       shift_en;

	// at most nine weights per burst
	assign shift_en = filter_valid && !busy && (shift_cnt != 4'(KER_TAPS));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shift_cnt <= '0;
		end else if (!filter_valid) begin
			shift_cnt <= '0;
		end else if (shift_en) begin
			shift_cnt <= shift_cnt + 4'd1;
		end
	end

	// --------------------------------------------------
	// shift chain, row-major weights
	// --------------------------------------------------

	// newest weight enters at the top, first one ends in tap 0
	always_ff @(posedge clk) begin
		if (shift_en) begin
			weights[KER_TAPS-1] <= in_data;
			for (int k = 0; k < KER_TAPS - 1; k++) begin
				weights[k] <= weights[k+1];
			end
		end
	end

endmodule

/* hw/image_store.sv */
module image_store import conv_pkg::*; #(
	parameter int IMG_MAX = 8
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      image_valid,
	input  logic      busy,
	input  pixel_t    in_data,
	input  img_size_t image_size,
	input  pad_mode_e pad_mode,
	input  act_mode_e act_mode,
	output img_size_t size,
	output pad_mode_e pad_sel,
	output act_mode_e act_sel,
	output logic      load_done,
	input  coord_t    rd_row,
	input  coord_t    rd_col,
	output pixel_t    rd_pixel
);

	localparam int AW = $clog2(IMG_MAX);

	pixel_t    mem [IMG_MAX][IMG_MAX];
	logic      loading;
	coord_t    wr_row;
	coord_t    wr_col;
	img_size_t eff_size;
	img_size_t last_idx;
	logic      wr_en;
	logic      row_end;
	logic      img_end;

	assign wr_en = image_valid && !busy;

	// first pixel still sees the live size input
	assign eff_size = loading ? size : image_size;
	assign last_idx = eff_size - 4'd1;
	assign row_end  = (wr_col == last_idx);
	assign img_end  = row_end && (wr_row == last_idx);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			loading   <= 1'b0;
			wr_row    <= '0;
			wr_col    <= '0;
			load_done <= 1'b0;
			size      <= '0;
			pad_sel   <= PAD_ZERO;
			act_sel   <= ACT_RELU;
		end else begin
			load_done <= 1'b0;
			if (wr_en) begin
				if (!loading) begin
					size    <= image_size;
					pad_sel <= pad_mode;
					act_sel <= act_mode;
				end
				loading   <= !img_end;
				load_done <= img_end;
				if (!row_end) begin
					wr_col <= wr_col + 4'd1;
				end else begin
					wr_col <= '0;
					wr_row <= img_end ? '0 : wr_row + 4'd1;
				end
			end
		end
	end

	// writes only while idle, reads only while busy
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_row[AW-1:0]][wr_col[AW-1:0]] <= in_data;
		end
		rd_pixel <= mem[rd_row[AW-1:0]][rd_col[AW-1:0]];
	end

endmodule

/* hw/mac_act.sv */
module mac_act import conv_pkg::*; #(
	parameter int ALPHA = 10
) (
	input  logic       clk,
	input  logic       rst_n,
	input  pixel_t     weights [KER_TAPS],
	input  pixel_t     rd_pixel,
	input  logic       tap_valid,
	input  logic [3:0] tap_index,
	input  logic       tap_zero,
	input  logic       first_tap,
	input  logic       last_tap,
	input  act_mode_e  act_out,
	output logic       out_valid,
	output result_t    out_data
);

	logic       d_valid;
	logic       d_zero;
	logic       d_first;
	logic       d_last;
	logic [3:0] d_index;
	pixel_t     px;
	prod_t      prod;
	acc_t       acc;
	acc_t       base;
	acc_t       sum;

	// leaky divide truncates toward zero
	function automatic result_t activate(input acc_t v, input act_mode_e mode);
		acc_t a;
		if (!v[$bits(acc_t)-1]) begin
			a = v;
		end else if (mode == ACT_LEAKY) begin
			a = acc_t'(v / ALPHA);
		end else begin
			a = '0;
		end
		if (a > acc_t'(RES_MAX)) begin
			activate = RES_MAX;
		end else if (a < acc_t'(RES_MIN)) begin
			activate = RES_MIN;
		end else begin
			activate = result_t'(a);
		end
	endfunction

	// line the controls up with the registered read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			d_valid <= 1'b0;
			d_zero  <= 1'b0;
			d_first <= 1'b0;
			d_last  <= 1'b0;
			d_index <= '0;
		end else begin
			d_valid <= tap_valid;
			d_zero  <= tap_zero;
			d_first <= first_tap;
			d_last  <= last_tap;
			d_index <= tap_index;
		end
	end

	assign px   = d_zero ? pixel_t'(0) : rd_pixel;
	assign prod = px * weights[d_index];
	assign base = d_first ? acc_t'(0) : acc;
	assign sum  = base + acc_t'(prod);

	always_ff @(posedge clk) begin
		if (d_valid) begin
			acc <= sum;
		end
		if (d_valid && d_last) begin
			out_data <= activate(sum, act_out);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= d_valid && d_last;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# builds the testbench with verilator and runs it from the project root

BUILD_DIR=obj_dir
SIM_BIN=conv_tb_sim
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module conv_tb -f flist.f \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi

echo "simulation passed"
exit 0
